// ==== common/ctrlPkg.sv ====
// Shared definitions for the pipeline control unit
// Field widths, opcode and format enums, stage control structs

package ctrlPkg;

  localparam int instrWidth  = 32;             // Instruction width
  localparam int regAdrWidth = 5;              // Register address width
  localparam int opWidth     = 7;              // Opcode field width

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [opWidth-1:0] {
    load   = 7'b0000011,                       // Loads
    fence  = 7'b0001111,                       // fence and fence.i
    opImm  = 7'b0010011,                       // I-type ALU
    auipc  = 7'b0010111,
    store  = 7'b0100011,                       // Stores
    op     = 7'b0110011,                       // R-type ALU
    lui    = 7'b0110111,
    branch = 7'b1100011,
    jalr   = 7'b1100111,
    jal    = 7'b1101111,
    system = 7'b1110011                        // CSR and privileged
  } opcodeT;

  typedef enum logic [2:0] {
    immI = 3'b000,
    immS = 3'b001,
    immB = 3'b010,
    immJ = 3'b011,
    immU = 3'b100
  } immSrcT;

  typedef enum logic [2:0] {
    resultAlu = 3'b000,                        // ALU or IEU result
    resultMem = 3'b001,                        // Load data
    resultCsr = 3'b010                         // CSR read data
  } resultSrcT;

  // Matches funct3 of the ALU ops
  typedef enum logic [2:0] {
    aluAdd  = 3'b000,
    aluSll  = 3'b001,
    aluSlt  = 3'b010,
    aluSltu = 3'b011,
    aluXor  = 3'b100,
    aluSr   = 3'b101,                          // srl or sra, picked by subArith
    aluOr   = 3'b110,
    aluAnd  = 3'b111
  } aluSelectT;

  ////////////////////////////////////////////////////////////
  // Stage control bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic read;                                // Bit 1
    logic write;                               // Bit 0
  } memRwT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    memRwT     memRw;
    logic      jump;
    logic      branch;
    logic      aluSrcA;                        // 1 selects PC
    logic      aluSrcB;                        // 1 selects immediate
    logic      aluResultSrc;                   // 1 passes IEU result instead of ALU
    logic      csrRead;
    logic      csrWrite;
    logic      privileged;
    logic      fenceI;
    logic [2:0] funct3;
    aluSelectT aluSelect;
    logic      subArith;                       // sub, sra, slt, sltu
  } decodeCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    memRwT     memRw;
    logic      csrRead;
    logic      csrWrite;
    logic      privileged;
    logic [2:0] funct3;
    logic      fenceI;
    logic      instrValid;
  } execCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
  } wbCtrlT;

endpackage

// ==== decode/instrDecoder.sv ====
// Decode-stage instruction decoder
// Field extraction, legality check, main decoder, ALU decode, CSR write rule

`timescale 1ns/1ps

module instrDecoder (
  input  logic [ctrlPkg::instrWidth-1:0] InstrD,      // Instruction in Decode
  output ctrlPkg::decodeCtrlT            DecodeCtrl,  // Controls passed on to Execute
  output ctrlPkg::immSrcT                ImmSrcD,     // Immediate format
  output logic                           IllegalBaseInstrD
);
  import ctrlPkg::*;

  opcodeT                 opD;
  logic [2:0]             funct3D;
  logic [6:0]             funct7D;
  logic [regAdrWidth-1:0] rs1D, rdD;
  logic                   funct7Zero, funct7Alt;   // 0000000, 0100000
  logic                   loadOk, storeOk, immOk, regOk, branchOk, jalrOk;
  logic                   privOk, csrOk;
  logic [18:0]            mainD;                   // Main decoder word
  logic [2:0]             immSrcBits, resultSrcBits;
  logic                   aluOpD;                  // 0 means address generation
  logic                   subD, sraD, sltD, sltuD;
  logic                   csrZeroSrcD;

  // Field extraction
  assign opD     = opcodeT'(InstrD[opWidth-1:0]);
  assign funct3D = InstrD[14:12];
  assign funct7D = InstrD[31:25];
  assign rs1D    = InstrD[19:15];
  assign rdD     = InstrD[11:7];

  ////////////////////////////////////////////////////////////
  // Exact legality of funct3 and funct7
  ////////////////////////////////////////////////////////////

  assign funct7Zero = (funct7D == 7'b0000000);
  assign funct7Alt  = (funct7D == 7'b0100000);
  assign loadOk     = (funct3D != 3'b011) & (funct3D[2:1] != 2'b11); // lb lh lw lbu lhu
  assign storeOk    = (funct3D[2] == 1'b0) & (funct3D[1:0] != 2'b11); // sb sh sw
  assign immOk      = (funct3D == 3'b001) ? funct7Zero :
                      (funct3D == 3'b101) ? (funct7Zero | funct7Alt) : 1'b1; // Shift amounts
  assign regOk      = funct7Zero | (funct7Alt & ((funct3D == 3'b000) | (funct3D == 3'b101)));
  assign branchOk   = (funct3D[2:1] != 2'b01);
  assign jalrOk     = (funct3D == 3'b000);
  assign privOk     = (funct3D == 3'b000) & (rdD == '0); // ecall, ebreak, mret and the like
  assign csrOk      = (funct3D[1:0] != 2'b00);

  ////////////////////////////////////////////////////////////
  // Main decoder
  ////////////////////////////////////////////////////////////

  // regWrite_immSrc_aluSrcA_aluSrcB_memRw_resultSrc_branch_aluOp_jump_aluResultSrc
  //   _csrRead_privileged_fenceI_illegal
  always_comb begin
    mainD = 19'b0_000_0_0_00_000_0_0_0_0_0_0_0_1; // Unknown or illegal
    case (opD)
      load:   if (loadOk)   mainD = 19'b1_000_0_1_10_001_0_0_0_0_0_0_0_0;
      fence:  if (funct3D == 3'b000)
                            mainD = 19'b0_000_0_0_00_000_0_0_0_0_0_0_0_0; // Plain fence is a nop
              else if (funct3D == 3'b001)
                            mainD = 19'b0_000_0_0_00_000_0_0_0_0_0_0_1_0; // fence.i
      opImm:  if (immOk)    mainD = 19'b1_000_0_1_00_000_0_1_0_0_0_0_0_0;
      auipc:                mainD = 19'b1_100_1_1_00_000_0_0_0_0_0_0_0_0;
      store:  if (storeOk)  mainD = 19'b0_001_0_1_01_000_0_0_0_0_0_0_0_0;
      op:     if (regOk)    mainD = 19'b1_000_0_0_00_000_0_1_0_0_0_0_0_0;
      lui:                  mainD = 19'b1_100_0_1_00_000_0_0_0_1_0_0_0_0;
      branch: if (branchOk) mainD = 19'b0_010_1_1_00_000_1_0_0_0_0_0_0_0;
      jalr:   if (jalrOk)   mainD = 19'b1_000_0_1_00_000_0_0_1_1_0_0_0_0;
      jal:                  mainD = 19'b1_011_1_1_00_000_0_0_1_1_0_0_0_0;
      system: if (privOk)   mainD = 19'b0_000_0_0_00_000_0_0_0_0_0_1_0_0;
              else if (csrOk)
                            mainD = 19'b1_000_0_0_00_010_0_0_0_0_1_0_0_0;
      default: ;                                 // Keeps the illegal word
    endcase
  end

  // Unpack the decoder word
  assign {DecodeCtrl.regWrite, immSrcBits, DecodeCtrl.aluSrcA, DecodeCtrl.aluSrcB,
          DecodeCtrl.memRw, resultSrcBits, DecodeCtrl.branch, aluOpD, DecodeCtrl.jump,
          DecodeCtrl.aluResultSrc, DecodeCtrl.csrRead, DecodeCtrl.privileged,
          DecodeCtrl.fenceI, IllegalBaseInstrD} = mainD;
  assign ImmSrcD              = immSrcT'(immSrcBits);
  assign DecodeCtrl.resultSrc = resultSrcT'(resultSrcBits);
  assign DecodeCtrl.funct3    = funct3D;

  ////////////////////////////////////////////////////////////
  // ALU decode and CSR write rule
  ////////////////////////////////////////////////////////////

  assign subD  = (funct3D == 3'b000) & funct7D[5] & opD[5]; // opD[5] tells sub from addi
  assign sraD  = (funct3D == 3'b101) & funct7D[5];
  assign sltD  = (funct3D == 3'b010);
  assign sltuD = (funct3D == 3'b011);
  assign DecodeCtrl.subArith  = aluOpD & (subD | sraD | sltD | sltuD);
  assign DecodeCtrl.aluSelect = aluOpD ? aluSelectT'(funct3D) : aluAdd; // Add for addresses

  // Set or clear with x0 or a zero immediate leaves the CSR untouched
  assign csrZeroSrcD         = (rs1D == '0);
  assign DecodeCtrl.csrWrite = DecodeCtrl.csrRead & ~(csrZeroSrcD & funct3D[1]);

endmodule

// ==== execute/executeCtrl.sv ====
// Execute-stage control register
// Branch resolution and store-after-load stall

`timescale 1ns/1ps

module executeCtrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  StallE, FlushE,
  input  ctrlPkg::decodeCtrlT   DecodeCtrl,      // From the decoder
  input  logic                  InstrValidD,
  input  logic [1:0]            FlagsE,          // {eq, lt}
  output ctrlPkg::execCtrlT     ExecCtrl,        // To the Memory register
  output logic                  PCSrcE,          // Redirect fetch
  output logic                  ALUSrcAE, ALUSrcBE,
  output logic                  ALUResultSrcE,
  output ctrlPkg::aluSelectT    ALUSelectE,
  output logic                  SubArithE,
  output logic                  BranchSignedE,
  output logic                  MemReadE, CSRReadE,
  output logic [2:0]            Funct3E,
  output logic                  JumpE, BranchE,
  output logic                  InstrValidE,
  output logic                  StoreStallD
);
  import ctrlPkg::*;

  decodeCtrlT ctrlE;                             // Execute control register
  logic       validE;
  logic       branchFlagE, branchTakenE;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlE  <= '0;
      validE <= 1'b0;
    end else if (!StallE) begin                  // Stall holds, flush ignored
      if (FlushE) begin
        ctrlE  <= '0;
        validE <= 1'b0;
      end else begin
        ctrlE  <= DecodeCtrl;
        validE <= InstrValidD;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////

  assign branchFlagE   = ctrlE.funct3[2] ? FlagsE[0] : FlagsE[1]; // lt for blt/bge, eq else
  assign branchTakenE  = branchFlagE ^ ctrlE.funct3[0];           // bne, bge, bgeu invert
  assign PCSrcE        = ctrlE.jump | (ctrlE.branch & branchTakenE);
  assign BranchSignedE = ctrlE.branch & (ctrlE.funct3[2:1] != 2'b11); // Not bltu/bgeu

  // Execute outputs
  assign ALUSrcAE      = ctrlE.aluSrcA;
  assign ALUSrcBE      = ctrlE.aluSrcB;
  assign ALUResultSrcE = ctrlE.aluResultSrc;
  assign ALUSelectE    = ctrlE.aluSelect;
  assign SubArithE     = ctrlE.subArith;
  assign MemReadE      = ctrlE.memRw.read;       // Load-use hazard detection
  assign CSRReadE      = ctrlE.csrRead;
  assign Funct3E       = ctrlE.funct3;
  assign JumpE         = ctrlE.jump;
  assign BranchE       = ctrlE.branch;
  assign InstrValidE   = validE;

  // Bundle on to Memory
  assign ExecCtrl = '{regWrite: ctrlE.regWrite, resultSrc: ctrlE.resultSrc,
                      memRw: ctrlE.memRw, csrRead: ctrlE.csrRead, csrWrite: ctrlE.csrWrite,
                      privileged: ctrlE.privileged, funct3: ctrlE.funct3,
                      fenceI: ctrlE.fenceI, instrValid: validE};

  // Memory is busy the cycle after a store
  assign StoreStallD = ctrlE.memRw.write & (DecodeCtrl.memRw.read | DecodeCtrl.memRw.write);

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module controllerTb \
  -f sim.f \
  -o controllerSim

./obj_dir/controllerSim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== sim.f ====
+incdir+test
common/ctrlPkg.sv
decode/instrDecoder.sv
execute/executeCtrl.sv
src/memWbCtrl.sv
src/controller.sv
test/controllerTb.sv

// ==== src/controller.sv ====
// Pipeline control unit top level
// Decoder, Execute and Memory/Writeback control, Decode valid register

`timescale 1ns/1ps

module controller (
  input  logic                           clk,
  input  logic                           reset,
  // Decode
  input  logic                           StallD, FlushD,
  input  logic [ctrlPkg::instrWidth-1:0] InstrD,
  output ctrlPkg::immSrcT                ImmSrcD,
  output logic                           IllegalBaseInstrD,
  output logic                           JumpD, BranchD,
  output logic                           InstrValidD,
  output logic                           StoreStallD,       // Store in E blocks memory op in D
  // Execute
  input  logic                           StallE, FlushE,
  input  logic [1:0]                     FlagsE,            // {eq, lt}
  output logic                           PCSrcE,
  output logic                           ALUSrcAE, ALUSrcBE,
  output logic                           ALUResultSrcE,
  output ctrlPkg::aluSelectT             ALUSelectE,
  output logic                           SubArithE,
  output logic                           BranchSignedE,
  output logic                           MemReadE, CSRReadE,
  output logic [2:0]                     Funct3E,
  output logic                           JumpE, BranchE,
  output logic                           InstrValidE,
  // Memory
  input  logic                           StallM, FlushM,
  output ctrlPkg::memRwT                 MemRWM,
  output logic                           CSRReadM, CSRWriteM, PrivilegedM,
  output logic [2:0]                     Funct3M,
  output logic                           RegWriteM,
  output logic                           InstrValidM,
  output logic                           CSRWriteFenceM,
  // Writeback
  input  logic                           StallW, FlushW,
  output logic                           RegWriteW,
  output ctrlPkg::resultSrcT             ResultSrcW
);
  import ctrlPkg::*;

  decodeCtrlT decodeCtrl;                        // Decoder to Execute
  execCtrlT   execCtrl;                          // Execute to Memory

  // Decode valid register, set one cycle after reset release
  always_ff @(posedge clk) begin
    if (reset)
      InstrValidD <= 1'b0;
    else if (!StallD)
      InstrValidD <= ~FlushD;
  end

  instrDecoder instrDecoder_i (
    .InstrD, .DecodeCtrl(decodeCtrl), .ImmSrcD, .IllegalBaseInstrD
  );

  assign JumpD   = decodeCtrl.jump;
  assign BranchD = decodeCtrl.branch;

  executeCtrl executeCtrl_i (
    .clk, .reset, .StallE, .FlushE, .DecodeCtrl(decodeCtrl), .InstrValidD, .FlagsE,
    .ExecCtrl(execCtrl), .PCSrcE, .ALUSrcAE, .ALUSrcBE, .ALUResultSrcE, .ALUSelectE,
    .SubArithE, .BranchSignedE, .MemReadE, .CSRReadE, .Funct3E, .JumpE, .BranchE,
    .InstrValidE, .StoreStallD
  );

  memWbCtrl memWbCtrl_i (
    .clk, .reset, .StallM, .FlushM, .StallW, .FlushW, .ExecCtrl(execCtrl),
    .MemRWM, .CSRReadM, .CSRWriteM, .PrivilegedM, .Funct3M, .RegWriteM, .InstrValidM,
    .CSRWriteFenceM, .RegWriteW, .ResultSrcW
  );

endmodule

// ==== src/memWbCtrl.sv ====
// Memory and Writeback control registers
// CSR-write or fence.i flush request

`timescale 1ns/1ps

module memWbCtrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                StallM, FlushM,
  input  logic                StallW, FlushW,
  input  ctrlPkg::execCtrlT   ExecCtrl,          // From Execute
  output ctrlPkg::memRwT      MemRWM,            // {read, write}
  output logic                CSRReadM, CSRWriteM, PrivilegedM,
  output logic [2:0]          Funct3M,
  output logic                RegWriteM,         // For the hazard unit
  output logic                InstrValidM,
  output logic                CSRWriteFenceM,    // Flush younger stages
  output logic                RegWriteW,
  output ctrlPkg::resultSrcT  ResultSrcW         // Writeback result mux
);
  import ctrlPkg::*;

  execCtrlT ctrlM;                               // Memory control register
  wbCtrlT   ctrlW;                               // Writeback control register

  always_ff @(posedge clk) begin
    if (reset)
      ctrlM <= '0;
    else if (!StallM)
      ctrlM <= FlushM ? '0 : ExecCtrl;
  end

  always_ff @(posedge clk) begin
    if (reset)
      ctrlW <= '0;
    else if (!StallW)
      ctrlW <= FlushW ? '0 : wbCtrlT'{regWrite: ctrlM.regWrite, resultSrc: ctrlM.resultSrc};
  end

  // Memory outputs
  assign MemRWM      = ctrlM.memRw;
  assign CSRReadM    = ctrlM.csrRead;
  assign CSRWriteM   = ctrlM.csrWrite;
  assign PrivilegedM = ctrlM.privileged;
  assign Funct3M     = ctrlM.funct3;
  assign RegWriteM   = ctrlM.regWrite;
  assign InstrValidM = ctrlM.instrValid;

  // A CSR write or fence.i may change how younger instructions behave
  assign CSRWriteFenceM = ctrlM.csrWrite | ctrlM.fenceI;

  // Writeback outputs
  assign RegWriteW  = ctrlW.regWrite;
  assign ResultSrcW = ctrlW.resultSrc;

endmodule

// ==== test/instrEncode.svh ====
// Instruction encoders for the controller testbench
// Legal RV32I word builder and expected decode, branch and flush rules

`ifndef INSTRENCODE_SVH
`define INSTRENCODE_SVH

// Every kept opcode by index
function automatic opcodeT pickOpcode(input int idx);
  case (idx)
    0:       return load;
    1:       return fence;
    2:       return opImm;
    3:       return auipc;
    4:       return store;
    5:       return op;
    6:       return lui;
    7:       return branch;
    8:       return jalr;
    9:       return jal;
    default: return system;
  endcase
endfunction

function automatic logic [31:0] makeInstr(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [6:0] opc);
  return {funct7, rs2, rs1, funct3, rd, opc};
endfunction

// Random fields from r, bent into a legal encoding of opc
function automatic logic [31:0] legalInstr(input opcodeT opc, input logic [31:0] r);
  logic [6:0] f7;
  logic [2:0] f3;
  f7 = r[31:25];
  f3 = r[14:12];
  case (opc)
    load:   f3 = (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3;          // lb lh lw lbu lhu
    store:  f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};     // sb sh sw
    opImm:  if (f3 == 3'd1) f7 = 7'b0;                              // slli
            else if (f3 == 3'd5) f7 = {1'b0, r[30], 5'b0};          // srli or srai
    op:     f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'b0} : 7'b0;
    branch: f3 = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;         // No 010 or 011
    jalr:   f3 = 3'd0;
    fence:  f3 = {2'b00, r[0]};                                     // fence or fence.i
    system: f3 = (f3[1:0] == 2'b00) ? {f3[2], 2'b01} : f3;          // CSR forms only
    default: ;
  endcase
  return makeInstr(f7, r[24:20], r[19:15], f3, r[11:7], opc);
endfunction

function automatic immSrcT expImmSrc(input opcodeT opc);
  case (opc)
    store:      return immS;
    branch:     return immB;
    jal:        return immJ;
    lui, auipc: return immU;
    default:    return immI;                   // Loads, opImm, jalr, fence, system
  endcase
endfunction

function automatic logic expRegWrite(input logic [31:0] instr);
  case (instr[6:0])
    load, opImm, auipc, op, lui, jalr, jal: return 1'b1;
    system:  return instr[14:12] != 3'b000;     // CSR ops write rd
    default: return 1'b0;
  endcase
endfunction

function automatic resultSrcT expResultSrc(input logic [31:0] instr);
  if (instr[6:0] == load)
    return resultMem;
  if (instr[6:0] == system && instr[14:12] != 3'b000)
    return resultCsr;
  return resultAlu;
endfunction

// {aluSrcA, aluSrcB, aluResultSrc}: PC operand, immediate operand, non-ALU result
function automatic logic [2:0] expAluSources(input logic [31:0] instr);
  case (instr[6:0])
    auipc, branch:      return 3'b110;         // PC plus immediate
    jal:                return 3'b111;         // Target from ALU, rd gets PC+4
    jalr, lui:          return 3'b011;
    load, store, opImm: return 3'b010;
    default:            return 3'b000;         // op, fence, system
  endcase
endfunction

function automatic aluSelectT expAluSelect(input logic [31:0] instr);
  if (instr[6:0] == op || instr[6:0] == opImm)
    return aluSelectT'(instr[14:12]);
  return aluAdd;                               // Address generation
endfunction

function automatic logic expSubArith(input logic [31:0] instr);
  if (instr[6:0] != op && instr[6:0] != opImm)
    return 1'b0;
  case (instr[14:12])
    3'b000:         return instr[30] && instr[6:0] == op; // sub, never addi
    3'b010, 3'b011: return 1'b1;               // slt, sltu
    3'b101:         return instr[30];          // sra
    default:        return 1'b0;
  endcase
endfunction

function automatic logic expCsrRead(input logic [31:0] instr);
  return instr[6:0] == system && instr[14:12] != 3'b000;
endfunction

// eq is flags[1], lt is flags[0]
function automatic logic expTaken(input logic [2:0] f3, input logic [1:0] flags);
  case (f3)
    3'b000:         return flags[1];           // beq
    3'b001:         return !flags[1];          // bne
    3'b100, 3'b110: return flags[0];           // blt, bltu
    3'b101, 3'b111: return !flags[0];          // bge, bgeu
    default:        return 1'b0;
  endcase
endfunction

// CSR write unless set or clear from zero, or fence.i
function automatic logic expFlushRequest(input logic [31:0] instr);
  if (instr[6:0] == fence)
    return instr[14:12] == 3'b001;
  if (instr[6:0] == system && instr[13:12] != 2'b00)
    return instr[13:12] == 2'b01 || instr[19:15] != 5'd0;
  return 1'b0;
endfunction

`endif

// ==== test/controllerTb.sv ====
// Testbench for the pipeline control unit
// Clock, reset, decode, pipeline, branch, stall, store stall and CSR flush tests

`timescale 1ns/1ps

module controllerTb;
  import ctrlPkg::*;

  `include "instrEncode.svh"

  localparam int clkPeriod  = 8;               // ns
  localparam int testCycles = 200;             // Upper bound of all tests
  localparam int margin     = 400;             // ns

  logic                  clk, reset;
  logic                  StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW;
  logic [instrWidth-1:0] InstrD;
  logic [1:0]            FlagsE;               // {eq, lt}
  immSrcT                ImmSrcD;
  logic                  IllegalBaseInstrD, JumpD, BranchD, InstrValidD, StoreStallD;
  logic                  PCSrcE, ALUSrcAE, ALUSrcBE, ALUResultSrcE, SubArithE;
  aluSelectT             ALUSelectE;
  logic                  BranchSignedE, MemReadE, CSRReadE, JumpE, BranchE, InstrValidE;
  logic [2:0]            Funct3E, Funct3M;
  memRwT                 MemRWM;
  logic                  CSRReadM, CSRWriteM, PrivilegedM, RegWriteM, InstrValidM;
  logic                  CSRWriteFenceM, RegWriteW;
  resultSrcT             ResultSrcW;
  integer                seed;
  int                    errors, checks;

  controller dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic checkCond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERR %0d ns: %s", $time, what);
    end
  endtask

  task automatic nextCycle();                  // Drive point, 1 ns past the edge
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic decodeTest();
    logic [31:0] rnd, instr;
    opcodeT      opc;
    for (int k = 0; k < 11; k++) begin
      for (int n = 0; n < 4; n++) begin
        rnd   = $random(seed);
        opc   = pickOpcode(k);
        instr = legalInstr(opc, rnd);
        nextCycle();
        InstrD = instr;
        @(negedge clk);                        // Decode is combinational
        checkCond(ImmSrcD == expImmSrc(opc), $sformatf("ImmSrcD %0d for %h", ImmSrcD, instr));
        checkCond(JumpD == (opc == jal || opc == jalr), $sformatf("JumpD for %h", instr));
        checkCond(BranchD == (opc == branch), $sformatf("BranchD for %h", instr));
        checkCond(!IllegalBaseInstrD, $sformatf("legal %h flagged illegal", instr));
      end
    end
  endtask

  task automatic illegalCase(input logic [31:0] instr);
    nextCycle();
    InstrD = instr;
    @(negedge clk);
    checkCond(IllegalBaseInstrD, $sformatf("illegal %h not flagged", instr));
    repeat (2) nextCycle();                    // Same word reaches Memory
    @(negedge clk);
    checkCond(!RegWriteM, $sformatf("illegal %h writes a register in Memory", instr));
  endtask

  task automatic pipelineTest();
    logic [31:0] rnd, instr;
    logic [31:0] hist [4];                     // Index is stage, 0 is Decode
    for (int i = 0; i < 40; i++) begin
      rnd   = $random(seed);
      instr = legalInstr(pickOpcode(rnd % 11), $random(seed));
      nextCycle();
      InstrD = instr;
      for (int s = 3; s > 0; s--)
        hist[s] = hist[s-1];
      hist[0] = instr;
      @(negedge clk);
      if (i >= 3) begin                        // History is full
        checkCond(MemReadE == (hist[1][6:0] == load), "MemReadE lags Decode by one cycle");
        checkCond({ALUSrcAE, ALUSrcBE, ALUResultSrcE} == expAluSources(hist[1]),
                  $sformatf("ALU sources in Execute for %h", hist[1]));
        checkCond(ALUSelectE == expAluSelect(hist[1]),
                  $sformatf("ALUSelectE %0d for %h", ALUSelectE, hist[1]));
        checkCond(SubArithE == expSubArith(hist[1]), $sformatf("SubArithE for %h", hist[1]));
        checkCond(CSRReadE == expCsrRead(hist[1]), $sformatf("CSRReadE for %h", hist[1]));
        checkCond(Funct3E == hist[1][14:12], "Funct3E lags Decode by one cycle");
        checkCond(BranchE == (hist[1][6:0] == branch), "BranchE lags Decode by one cycle");
        checkCond(RegWriteM == expRegWrite(hist[2]), "RegWriteM lags Decode by two cycles");
        checkCond(MemRWM == {hist[2][6:0] == load, hist[2][6:0] == store},
                  $sformatf("MemRWM for %h", hist[2]));
        checkCond(CSRReadM == expCsrRead(hist[2]), $sformatf("CSRReadM for %h", hist[2]));
        checkCond(CSRWriteM == (expFlushRequest(hist[2]) && hist[2][6:0] != fence),
                  $sformatf("CSRWriteM for %h", hist[2]));
        checkCond(PrivilegedM == (hist[2][6:0] == system && hist[2][14:12] == 3'b000),
                  $sformatf("PrivilegedM for %h", hist[2]));
        checkCond(Funct3M == hist[2][14:12], "Funct3M lags Decode by two cycles");
        checkCond(RegWriteW == expRegWrite(hist[3]), "RegWriteW lags Decode by three cycles");
        checkCond(ResultSrcW == expResultSrc(hist[3]), "ResultSrcW lags Decode by three cycles");
        checkCond(InstrValidD && InstrValidE && InstrValidM, "InstrValid low in D, E or M");
      end
    end
  endtask

  task automatic branchTest();
    logic [31:0] rnd;
    logic [2:0]  f3;
    for (int b = 0; b < 8; b++) begin
      f3 = b[2:0];
      if (f3[2:1] == 2'b01)
        continue;                              // Not a branch funct3
      rnd = $random(seed);
      nextCycle();
      StallE = 1'b0;
      InstrD = makeInstr(rnd[31:25], rnd[24:20], rnd[19:15], f3, rnd[11:7], branch);
      for (int f = 0; f < 4; f++) begin
        nextCycle();
        StallE = 1'b1;                         // Branch stays in Execute
        FlagsE = f[1:0];
        @(negedge clk);
        checkCond(PCSrcE == expTaken(f3, FlagsE),
                  $sformatf("PCSrcE %b for funct3 %b flags %b", PCSrcE, f3, FlagsE));
        checkCond(BranchSignedE == !(f3 == 3'b110 || f3 == 3'b111),
                  $sformatf("BranchSignedE for funct3 %b", f3));
      end
    end
    for (int j = 0; j < 2; j++) begin          // jal, then jalr
      nextCycle();
      StallE = 1'b0;
      FlagsE = 2'b00;
      InstrD = legalInstr(j == 0 ? jal : jalr, $random(seed));
      nextCycle();
      @(negedge clk);
      checkCond(PCSrcE && JumpE, "jump does not set PCSrcE");
    end
  endtask

  task automatic stallFlushTest();
    nextCycle();
    InstrD = legalInstr(jal, $random(seed));
    nextCycle();                               // jal now in Execute
    StallE = 1'b1;
    FlushE = 1'b1;
    InstrD = legalInstr(opImm, $random(seed));
    repeat (2) begin
      nextCycle();
      @(negedge clk);
      checkCond(PCSrcE && JumpE && InstrValidE, "stalled Execute lost its contents");
    end
    nextCycle();
    StallE = 1'b0;                             // Flush takes effect next edge
    nextCycle();
    FlushE = 1'b0;
    @(negedge clk);
    checkCond(!InstrValidE && !PCSrcE, "unstalled flush left Execute valid");
  endtask

  task automatic storeStallTest();
    opcodeT eOp, dOp;
    for (int e = 0; e < 2; e++) begin
      eOp = pickOpcode(e == 0 ? 4 : 0);        // Store, then load in Execute
      nextCycle();
      StallE = 1'b0;
      InstrD = legalInstr(eOp, $random(seed));
      for (int d = 0; d < 4; d++) begin
        dOp = pickOpcode(d == 0 ? 0 : d == 1 ? 4 : d == 2 ? 5 : 7);
        nextCycle();
        StallE = 1'b1;
        InstrD = legalInstr(dOp, $random(seed));
        @(negedge clk);
        checkCond(StoreStallD == (eOp == store && (dOp == load || dOp == store)),
                  $sformatf("StoreStallD %b with %s in E, %s in D", StoreStallD,
                            eOp.name(), dOp.name()));
      end
    end
    nextCycle();
    StallE = 1'b0;
  endtask

  task automatic flushReqCase(input logic [31:0] instr);
    nextCycle();
    InstrD = instr;
    nextCycle();
    InstrD = makeInstr(7'b0, 5'd0, 5'd0, 3'b000, 5'd0, opImm); // nop behind it
    nextCycle();                               // Now in Memory
    @(negedge clk);
    checkCond(CSRWriteFenceM == expFlushRequest(instr),
              $sformatf("CSRWriteFenceM %b for %h", CSRWriteFenceM, instr));
    checkCond(PrivilegedM == (instr[6:0] == system && instr[14:12] == 3'b000),
              $sformatf("PrivilegedM %b for %h", PrivilegedM, instr));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed   = 32'hff4dc878;
    errors = 0;
    checks = 0;
    reset  = 1'b1;
    {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} = '0;
    InstrD = '0;
    FlagsE = '0;
    repeat (4) @(posedge clk);
    #1;
    checkCond(!(InstrValidD | InstrValidE | InstrValidM | RegWriteM | RegWriteW | PCSrcE |
                MemRWM.read | MemRWM.write | CSRWriteM | CSRWriteFenceM | StoreStallD),
              "control outputs not cleared by reset");
    reset = 1'b0;
    decodeTest();
    illegalCase(makeInstr(7'b0000001, 5'd3, 5'd2, 3'b000, 5'd1, op));     // mul
    illegalCase(makeInstr(7'b0, 5'd3, 5'd2, 3'b010, 5'd1, branch));
    illegalCase(makeInstr(7'b0, 5'd3, 5'd2, 3'b011, 5'd1, branch));
    illegalCase(makeInstr(7'b0, 5'd3, 5'd2, 3'b010, 5'd1, 7'b0101111));   // AMO
    pipelineTest();
    branchTest();
    stallFlushTest();
    storeStallTest();
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd7, 3'b001, 5'd1, system));      // csrrw
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd0, 3'b001, 5'd0, fence));       // fence.i
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd0, 3'b010, 5'd1, system));      // csrrs x0
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd9, 3'b011, 5'd1, system));      // csrrc
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd0, 3'b110, 5'd1, system));      // csrrsi 0
    flushReqCase(makeInstr(7'b0, 5'd0, 5'd0, 3'b000, 5'd0, system));      // ecall
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog
  initial begin
    #(testCycles * clkPeriod + margin);
    $display("Timeout: the tests did not complete within %0d cycles", testCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule
